//--- common/hc_macros.svh
`ifndef HC_MACROS_SVH
`define HC_MACROS_SVH

// fixed sizes of the avalon read to packet bridge
// a line is one 64 bit word on both the avalon side and the packet side

// width of one data line
`define HC_DATA_W 64
// line address width, byte address bits below one line are dropped
`define HC_ADDR_W 26
// avalon burst count, wide enough to hold 64
`define HC_BURST_W 7

// longest read packet, in lines
`define HC_MAX_PAYLOAD_LINES 8
// a 4 KB page holds 512 lines of 8 bytes
`define HC_PAGE_LINES 512

// reorder buffer geometry, the index width must match the depth
`define HC_ROB_DEPTH 32
`define HC_ROB_IDX_W 5
// packet length field, holds 1 to 8
`define HC_TLP_LEN_W 4

`endif

//--- common/hc_pkg.sv
`include "hc_macros.svh"

// shared types for the avalon read bridge
// widths come from hc_macros.svh so every block agrees on them
package hc_pkg;

    // ==============================
    //  data path types
    // ==============================

    // address of one 64 bit line
    typedef logic [`HC_ADDR_W-1:0] line_addr_t;

    // one line of read data
    typedef logic [`HC_DATA_W-1:0] line_data_t;

    // avalon burst length in lines
    typedef logic [`HC_BURST_W-1:0] burst_cnt_t;

    // packet length in lines, never zero and never above the max payload
    typedef logic [`HC_TLP_LEN_W-1:0] tlp_len_t;

    // reorder buffer slot, the first slot of a packet doubles as its tag
    typedef logic [`HC_ROB_IDX_W-1:0] rob_idx_t;

    // ==============================
    //  control types
    // ==============================

    // splitter state, idle waits for a command, busy cuts it into packets
    typedef enum logic
    {
        SPLIT_IDLE,
        SPLIT_BUSY
    } split_state_t;

endpackage

//--- common/rob_alloc_if.sv
// slot allocation between the request splitter and the reorder buffer
//
// the splitter asks for alloc_lines slots, the buffer grants in the same
// cycle whenever enough slots are free, and a cycle with both req and
// grant reserves the run of slots that starts at alloc_idx
interface rob_alloc_if;

    // request side, driven by the splitter
    logic               alloc_req;
    hc_pkg::tlp_len_t   alloc_lines;

    // grant side, driven by the buffer
    logic               alloc_grant;
    hc_pkg::rob_idx_t   alloc_idx;

    modport splitter
    (
        output alloc_req,
        output alloc_lines,
        input  alloc_grant,
        input  alloc_idx
    );

    modport buffer
    (
        input  alloc_req,
        input  alloc_lines,
        output alloc_grant,
        output alloc_idx
    );

endinterface

//--- common/rob_rd_if.sv
// head slot access between the in-order drain and the reorder buffer
//
// the drain presents the index of the oldest slot, the buffer answers
// with that slot's valid bit and data, and pop releases the slot so the
// buffer can hand it out again
interface rob_rd_if;

    // driven by the drain
    hc_pkg::rob_idx_t   head_idx;
    logic               pop;

    // driven by the buffer, purely combinational from head_idx
    logic               head_valid;
    hc_pkg::line_data_t head_data;

    modport drain
    (
        output head_idx,
        output pop,
        input  head_valid,
        input  head_data
    );

    modport buffer
    (
        input  head_idx,
        input  pop,
        output head_valid,
        output head_data
    );

endinterface

//--- dv/hc_avalon_rd_props.sv
`include "hc_macros.svh"

// concurrent checks on the packet and read response ports of the bridge
module hc_avalon_rd_props
(
    input logic                     clk,
    input logic                     reset,
    input logic                     avm_readdatavalid,
    input logic                     tlp_req_valid,
    input logic                     tlp_req_ready,
    input logic [`HC_ADDR_W-1:0]    tlp_req_addr,
    input logic [`HC_TLP_LEN_W-1:0] tlp_req_len,
    input logic [`HC_ROB_IDX_W-1:0] tlp_req_tag
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PAGE_OFS_W = $clog2(`HC_PAGE_LINES);

    // offset just past the last line of the packet, within its page
    logic [PAGE_OFS_W:0] pkt_end;

    assign pkt_end = {1'b0, tlp_req_addr[PAGE_OFS_W-1:0]} + (PAGE_OFS_W + 1)'(tlp_req_len);

    // a stalled packet keeps every field until the host takes it
    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        tlp_req_valid && !tlp_req_ready |=> tlp_req_valid && $stable(tlp_req_addr)
            && $stable(tlp_req_len) && $stable(tlp_req_tag))
        else $error("packet fields changed while stalled");

    a_len_range: assert property (@(posedge clk) disable iff (reset)
        tlp_req_valid |-> tlp_req_len >= 1 && tlp_req_len <= `HC_MAX_PAYLOAD_LINES)
        else $error("packet length out of range");

    // the last line of a packet may sit on the final line of a page
    a_page_bound: assert property (@(posedge clk) disable iff (reset)
        tlp_req_valid |-> pkt_end <= (PAGE_OFS_W + 1)'(`HC_PAGE_LINES))
        else $error("packet crosses a 4 KB page");

    a_quiet_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !avm_readdatavalid)
        else $error("read data returned during reset");

endmodule

//--- dv/tb_hc_avalon_rd.sv
`include "hc_macros.svh"

// testbench for the avalon read to packet bridge with a host model that
// completes packets out of order
module tb_hc_avalon_rd;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_W = `HC_ADDR_W;
    localparam int BURST_W = `HC_BURST_W;
    localparam int LEN_W = `HC_TLP_LEN_W;
    localparam int PAGE = `HC_PAGE_LINES;
    localparam int DEPTH = `HC_ROB_DEPTH;

    logic                       clk;
    logic                       reset;
    logic                       avm_read;
    logic [ADDR_W-1:0]          avm_address;
    logic [BURST_W-1:0]         avm_burstcount;
    logic                       avm_waitrequest;
    logic [`HC_DATA_W-1:0]      avm_readdata;
    logic                       avm_readdatavalid;
    logic                       tlp_req_valid;
    logic                       tlp_req_ready;
    logic [ADDR_W-1:0]          tlp_req_addr;
    logic [LEN_W-1:0]           tlp_req_len;
    logic [`HC_ROB_IDX_W-1:0]   tlp_req_tag;
    logic                       cpl_valid;
    logic [`HC_ROB_IDX_W-1:0]   cpl_tag;
    logic [LEN_W-1:0]           cpl_line;
    logic [`HC_DATA_W-1:0]      cpl_data;

    // ==============================
    //  model state
    // ==============================

    logic [31:0]                lfsr;
    // lines the AFU should see, in command order
    logic [`HC_DATA_W-1:0]      exp_data [$];
    // packets the split rule predicts, in issue order
    logic [ADDR_W-1:0]          exp_pkt_addr [$];
    int                         exp_pkt_len [$];
    // lines of taken packets that the host has not completed yet
    logic [`HC_ROB_IDX_W-1:0]   pend_tag [$];
    int                         pend_line [$];
    logic [ADDR_W-1:0]          pend_addr [$];
    logic [DEPTH-1:0]           slot_busy;
    int                         exp_tag;
    int                         out_lines;
    int                         cmd_lines;
    int                         issued_lines;
    int                         sent_lines;
    int                         rcvd_lines;
    int                         test_pkts;
    int                         pkt_total;
    int                         err_cnt;
    bit                         hold_cpl;
    bit                         ready_gaps;
    bit                         timed_out;

    hc_avalon_rd_top uut (.*);

    bind hc_avalon_rd_top hc_avalon_rd_props props
    (
        .clk(clk),
        .reset(reset),
        .avm_readdatavalid(avm_readdatavalid),
        .tlp_req_valid(tlp_req_valid),
        .tlp_req_ready(tlp_req_ready),
        .tlp_req_addr(tlp_req_addr),
        .tlp_req_len(tlp_req_len),
        .tlp_req_tag(tlp_req_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // ==============================
    //  helpers
    // ==============================

    // galois form of x^32 + x^22 + x^2 + x + 1, one output bit per step
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
        begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // host memory content, every line differs from its neighbours
    function automatic logic [`HC_DATA_W-1:0] scramble_line(input logic [ADDR_W-1:0] a);
        return {6'h2d, a, 6'h12, ~a} ^ 64'h5a5a_c3c3_0ff0_9669;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
        input logic [63:0] want);
        err_cnt++;
        $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, want);
    endtask

    task automatic report_error(input string what);
        err_cnt++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // cut a burst by the payload and page limits and queue its lines
    task automatic expect_burst(input logic [ADDR_W-1:0] addr, input int cnt);
        logic [ADDR_W-1:0] a;
        int rem;
        int step;
        a = addr;
        rem = cnt;
        while (rem > 0)
        begin
            step = `HC_MAX_PAYLOAD_LINES;
            if (rem < step)
            begin
                step = rem;
            end
            if (PAGE - int'(a) % PAGE < step)
            begin
                step = PAGE - int'(a) % PAGE;
            end
            exp_pkt_addr.push_back(a);
            exp_pkt_len.push_back(step);
            a = a + ADDR_W'(step);
            rem = rem - step;
        end
        for (int i = 0; i < cnt; i++)
        begin
            exp_data.push_back(scramble_line(addr + ADDR_W'(i)));
        end
        cmd_lines += cnt;
    endtask

    // ==============================
    //  host model
    // ==============================

    task automatic check_readdata();
        logic [`HC_DATA_W-1:0] want;
        if (avm_readdatavalid)
        begin
            rcvd_lines++;
            out_lines--;
            if (exp_data.size() == 0)
            begin
                report_error("readdatavalid with no line outstanding");
            end
            else
            begin
                want = exp_data.pop_front();
                if (avm_readdata !== want)
                begin
                    report_value("avm_readdata", avm_readdata, want);
                end
            end
        end
    endtask

    // the packet on the bus transfers at the coming rising edge
    task automatic take_packet();
        int len;
        int slot;
        len = int'(tlp_req_len);
        test_pkts++;
        pkt_total++;
        if (len < 1 || len > `HC_MAX_PAYLOAD_LINES)
        begin
            report_value("tlp_req_len", 64'(tlp_req_len), 64'(`HC_MAX_PAYLOAD_LINES));
        end
        if (int'(tlp_req_addr) % PAGE + len > PAGE)
        begin
            report_error("packet crosses a 4 KB page");
        end
        // slots are handed out as one ring, so each tag follows the last packet
        if (int'(tlp_req_tag) != exp_tag)
        begin
            report_value("tlp_req_tag", 64'(tlp_req_tag), 64'(exp_tag));
        end
        exp_tag = (exp_tag + len) % DEPTH;
        if (exp_pkt_addr.size() == 0)
        begin
            report_error("packet issued with no command left to split");
        end
        else
        begin
            if (tlp_req_addr !== exp_pkt_addr[0])
            begin
                report_value("tlp_req_addr", 64'(tlp_req_addr), 64'(exp_pkt_addr[0]));
            end
            if (len != exp_pkt_len[0])
            begin
                report_value("tlp_req_len", 64'(len), 64'(exp_pkt_len[0]));
            end
            void'(exp_pkt_addr.pop_front());
            void'(exp_pkt_len.pop_front());
        end
        for (int i = 0; i < len; i++)
        begin
            slot = (int'(tlp_req_tag) + i) % DEPTH;
            if (slot_busy[slot])
            begin
                report_error("slot handed out again before its line came back");
            end
            slot_busy[slot] = 1'b1;
            pend_tag.push_back(tlp_req_tag);
            pend_line.push_back(i);
            pend_addr.push_back(tlp_req_addr + ADDR_W'(i));
        end
        issued_lines += len;
        out_lines += len;
    endtask

    task automatic run_host();
        int k;
        logic rdy;
        // one completion beat per cycle at most, picked at random
        cpl_valid = 1'b0;
        if (!hold_cpl && pend_tag.size() > 0 && rand_bits(2) != 0)
        begin
            k = int'(rand_bits(8)) % pend_tag.size();
            cpl_valid = 1'b1;
            cpl_tag = pend_tag[k];
            cpl_line = LEN_W'(pend_line[k]);
            cpl_data = scramble_line(pend_addr[k]);
            slot_busy[(int'(pend_tag[k]) + pend_line[k]) % DEPTH] = 1'b0;
            pend_tag.delete(k);
            pend_line.delete(k);
            pend_addr.delete(k);
            sent_lines++;
        end
        rdy = ready_gaps ? lfsr_bit() : 1'b1;
        tlp_req_ready = rdy;
        if (tlp_req_valid && rdy)
        begin
            take_packet();
        end
        if (out_lines > DEPTH)
        begin
            report_error("more lines outstanding than the reorder buffer holds");
        end
    endtask

    // every input changes on the falling edge
    task automatic step_cycle();
        @(negedge clk);
        check_readdata();
        run_host();
    endtask

    // ==============================
    //  AFU side
    // ==============================

    task automatic issue_cmd(input logic [ADDR_W-1:0] addr, input int cnt);
        int waited;
        if (timed_out)
        begin
            return;
        end
        avm_read = 1'b1;
        avm_address = addr;
        avm_burstcount = BURST_W'(cnt);
        waited = 0;
        while (avm_waitrequest && waited < 400)
        begin
            step_cycle();
            waited++;
        end
        if (avm_waitrequest)
        begin
            report_error("read command not accepted before the timeout");
            timed_out = 1'b1;
        end
        else
        begin
            // waitrequest is low here, so the coming edge takes the command
            expect_burst(addr, cnt);
        end
        step_cycle();
        avm_read = 1'b0;
    endtask

    function automatic bit all_drained();
        return exp_data.size() == 0 && pend_tag.size() == 0 && exp_pkt_addr.size() == 0
            && !tlp_req_valid && !avm_waitrequest;
    endfunction

    task automatic wait_idle(input int limit);
        int waited;
        if (timed_out)
        begin
            return;
        end
        waited = 0;
        while (!all_drained() && waited < limit)
        begin
            step_cycle();
            waited++;
        end
        if (!all_drained())
        begin
            report_error("outstanding reads did not drain before the timeout");
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (err_cnt == err_before)
        begin
            $display("%s passed", name);
        end
        else
        begin
            $display("%s failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    // ==============================
    //  test sequence
    // ==============================

    initial
    begin
        int err_before;
        int cnt;
        int waited;
        logic [ADDR_W-1:0] base;
        lfsr = 32'h2b95;
        reset = 1'b1;
        avm_read = 1'b0;
        avm_address = '0;
        avm_burstcount = '0;
        tlp_req_ready = 1'b0;
        cpl_valid = 1'b0;
        cpl_tag = '0;
        cpl_line = '0;
        cpl_data = '0;
        slot_busy = '0;
        exp_tag = 0;
        out_lines = 0;
        cmd_lines = 0;
        issued_lines = 0;
        sent_lines = 0;
        rcvd_lines = 0;
        test_pkts = 0;
        pkt_total = 0;
        err_cnt = 0;
        hold_cpl = 1'b0;
        ready_gaps = 1'b0;
        timed_out = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        step_cycle();

        // short burst well inside one page gives a single packet
        err_before = err_cnt;
        test_pkts = 0;
        base = ADDR_W'(rand_bits(17) * PAGE + 64);
        issue_cmd(base, 5);
        wait_idle(500);
        if (test_pkts != 1)
        begin
            report_value("packet count", 64'(test_pkts), 64'd1);
        end
        finish_test("case 1 short burst", err_before);

        // 20 lines from offset 509 split as 3, 8, 8 and 1
        err_before = err_cnt;
        test_pkts = 0;
        base = ADDR_W'(rand_bits(17) * PAGE + 509);
        issue_cmd(base, 20);
        wait_idle(500);
        if (test_pkts != 4)
        begin
            report_value("packet count", 64'(test_pkts), 64'd4);
        end
        finish_test("case 2 page crossing", err_before);

        err_before = err_cnt;
        test_pkts = 0;
        base = ADDR_W'(rand_bits(17) * PAGE + 256);
        issue_cmd(base, 64);
        wait_idle(1000);
        if (test_pkts != 8)
        begin
            report_value("packet count", 64'(test_pkts), 64'd8);
        end
        finish_test("case 3 long burst", err_before);

        // several bursts in flight while the host completes at random
        err_before = err_cnt;
        for (int n = 0; n < 6; n++)
        begin
            base = ADDR_W'(rand_bits(ADDR_W));
            cnt = int'(rand_bits(6)) + 1;
            issue_cmd(base, cnt);
        end
        wait_idle(2000);
        finish_test("case 4 out of order completions", err_before);

        // with completions held the buffer fills and the splitter must stall
        err_before = err_cnt;
        hold_cpl = 1'b1;
        issue_cmd(ADDR_W'(rand_bits(17) * PAGE), 64);
        waited = 0;
        while (out_lines < DEPTH && waited < 200)
        begin
            step_cycle();
            waited++;
        end
        if (out_lines != DEPTH)
        begin
            report_value("outstanding lines", 64'(out_lines), 64'(DEPTH));
        end
        repeat (30)
        begin
            step_cycle();
            if (!avm_waitrequest)
            begin
                report_error("waitrequest fell while the reorder buffer was full");
            end
        end
        hold_cpl = 1'b0;
        wait_idle(1000);
        finish_test("case 5 full reorder buffer", err_before);

        err_before = err_cnt;
        ready_gaps = 1'b1;
        for (int n = 0; n < 6; n++)
        begin
            base = ADDR_W'(rand_bits(ADDR_W));
            cnt = int'(rand_bits(6)) + 1;
            issue_cmd(base, cnt);
        end
        wait_idle(3000);
        ready_gaps = 1'b0;
        // every commanded line was issued once, completed once and returned once
        if (issued_lines != cmd_lines)
        begin
            report_value("issued lines", 64'(issued_lines), 64'(cmd_lines));
        end
        if (sent_lines != cmd_lines)
        begin
            report_value("completed lines", 64'(sent_lines), 64'(cmd_lines));
        end
        if (rcvd_lines != cmd_lines)
        begin
            report_value("returned lines", 64'(rcvd_lines), 64'(cmd_lines));
        end
        if (slot_busy != '0)
        begin
            report_error("a slot is still waiting for its completion");
        end
        finish_test("case 6 ready gaps", err_before);

        $display("lines %0d, packets %0d, errors %0d", rcvd_lines, pkt_total, err_cnt);
        if (err_cnt == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- rob/rob_buffer.sv
`include "hc_macros.svh"

// reorder storage for read completions
//
// slots are handed out in a ring, in request order, and completions land
// in whatever order the host returns them. the drain reads the ring head
// and releases slots one at a time
module rob_buffer
(
    input  logic                clk,
    input  logic                reset,

    // completion beats from the host, one line each, no back-pressure
    input  logic                cpl_valid,
    input  hc_pkg::rob_idx_t    cpl_tag,
    input  hc_pkg::tlp_len_t    cpl_line,
    input  hc_pkg::line_data_t  cpl_data,

    rob_alloc_if.buffer         alloc,
    rob_rd_if.buffer            rd
);

    // free count spans 0 to the full depth, one bit wider than an index
    localparam int CNT_W = $clog2(`HC_ROB_DEPTH) + 1;

    hc_pkg::line_data_t         slot_data [`HC_ROB_DEPTH];
    logic [`HC_ROB_DEPTH-1:0]   slot_valid;
    hc_pkg::rob_idx_t           alloc_ptr;
    logic [CNT_W-1:0]           free_cnt;

    logic                       alloc_take;
    logic [CNT_W-1:0]           take_cnt;
    hc_pkg::rob_idx_t           cpl_idx;

    // ==============================
    //  allocation
    // ==============================

    // grant whenever the whole packet fits, the splitter decides if it asks
    assign alloc.alloc_grant = free_cnt >= CNT_W'(alloc.alloc_lines);
    assign alloc.alloc_idx = alloc_ptr;
    assign alloc_take = alloc.alloc_req && alloc.alloc_grant;
    assign take_cnt = alloc_take ? CNT_W'(alloc.alloc_lines) : '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alloc_ptr <= '0;
            free_cnt <= CNT_W'(`HC_ROB_DEPTH);
        end
        else
        begin
            // the index wraps by itself since the depth is a power of two
            if (alloc_take)
            begin
                alloc_ptr <= alloc_ptr + hc_pkg::rob_idx_t'(alloc.alloc_lines);
            end
            // a grant and a pop can land in the same cycle
            free_cnt <= free_cnt - take_cnt + CNT_W'(rd.pop);
        end
    end

    // ==============================
    //  completion write
    // ==============================

    // line n of a packet lives n slots after its tag, modulo the depth
    assign cpl_idx = cpl_tag + hc_pkg::rob_idx_t'(cpl_line);

    always_ff @(posedge clk)
    begin
        if (cpl_valid)
        begin
            slot_data[cpl_idx] <= cpl_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot_valid <= '0;
        end
        else
        begin
            // a slot is popped only once valid, and refilled only after reuse
            if (rd.pop)
            begin
                slot_valid[rd.head_idx] <= 1'b0;
            end
            if (cpl_valid)
            begin
                slot_valid[cpl_idx] <= 1'b1;
            end
        end
    end

    // ==============================
    //  head read
    // ==============================

    // a line written at an edge shows up here the following cycle
    assign rd.head_valid = slot_valid[rd.head_idx];
    assign rd.head_data = slot_data[rd.head_idx];

endmodule

//--- rob/rob_drain.sv
// in-order drain of the reorder buffer onto the avalon read response
//
// the head pointer walks the slot ring in allocation order, which is the
// order the packets were requested, so avalon sees data in command order
// even when the host completes packets out of order
module rob_drain
(
    input  logic                clk,
    input  logic                reset,

    // avalon read response toward the AFU
    output hc_pkg::line_data_t  avm_readdata,
    output logic                avm_readdatavalid,

    rob_rd_if.drain             rd
);

    // oldest slot still owned by an outstanding read
    hc_pkg::rob_idx_t   head_ptr;

    assign rd.head_idx = head_ptr;

    // the slot is released the same cycle its data is captured below
    assign rd.pop = rd.head_valid;

    // ==============================
    //  head pointer and response
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head_ptr <= '0;
            avm_readdatavalid <= 1'b0;
        end
        else
        begin
            // one line per cycle at most, pulse follows the head by a cycle
            avm_readdatavalid <= rd.head_valid;
            if (rd.head_valid)
            begin
                head_ptr <= head_ptr + hc_pkg::rob_idx_t'(1);
            end
        end
    end

    // response data only matters while readdatavalid is high
    always_ff @(posedge clk)
    begin
        if (rd.head_valid)
        begin
            avm_readdata <= rd.head_data;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hc_avalon_rd -Mdir obj_dir -f src.f \
    && ./obj_dir/Vtb_hc_avalon_rd | tee /dev/stderr | grep -F "Test OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src.f
+incdir+common
common/hc_pkg.sv
common/rob_alloc_if.sv
common/rob_rd_if.sv
src/tlp_rd_splitter.sv
src/hc_avalon_rd_top.sv
rob/rob_buffer.sv
rob/rob_drain.sv
dv/hc_avalon_rd_props.sv
dv/tb_hc_avalon_rd.sv

//--- src/hc_avalon_rd_top.sv
// avalon host memory read port mapped onto read request packets
//
// the splitter turns each avalon burst into page and payload bounded
// packets, the reorder buffer collects completions by slot and the drain
// hands lines back to the AFU in request order
module hc_avalon_rd_top
(
    input  logic                clk,
    input  logic                reset,

    // avalon read source, driven by the AFU
    input  logic                avm_read,
    input  hc_pkg::line_addr_t  avm_address,
    input  hc_pkg::burst_cnt_t  avm_burstcount,
    output logic                avm_waitrequest,
    output hc_pkg::line_data_t  avm_readdata,
    output logic                avm_readdatavalid,

    // read request packets to the host
    output logic                tlp_req_valid,
    input  logic                tlp_req_ready,
    output hc_pkg::line_addr_t  tlp_req_addr,
    output hc_pkg::tlp_len_t    tlp_req_len,
    output hc_pkg::rob_idx_t    tlp_req_tag,

    // completions from the host, possibly out of order
    input  logic                cpl_valid,
    input  hc_pkg::rob_idx_t    cpl_tag,
    input  hc_pkg::tlp_len_t    cpl_line,
    input  hc_pkg::line_data_t  cpl_data
);

    // ==============================
    //  internal buses
    // ==============================

    rob_alloc_if alloc_bus();
    rob_rd_if rd_bus();

    // ==============================
    //  request side
    // ==============================

    tlp_rd_splitter splitter
    (
        .clk,
        .reset,
        .avm_read,
        .avm_address,
        .avm_burstcount,
        .avm_waitrequest,
        .tlp_req_valid,
        .tlp_req_ready,
        .tlp_req_addr,
        .tlp_req_len,
        .tlp_req_tag,
        .alloc(alloc_bus.splitter)
    );

    // ==============================
    //  completion side
    // ==============================

    rob_buffer rob
    (
        .clk,
        .reset,
        .cpl_valid,
        .cpl_tag,
        .cpl_line,
        .cpl_data,
        .alloc(alloc_bus.buffer),
        .rd(rd_bus.buffer)
    );

    // read data leaves strictly in slot order
    rob_drain drain
    (
        .clk,
        .reset,
        .avm_readdata,
        .avm_readdatavalid,
        .rd(rd_bus.drain)
    );

endmodule

//--- src/tlp_rd_splitter.sv
`include "hc_macros.svh"

// cuts avalon read bursts into read request packets
//
// each packet is bounded by the lines left in the burst, the max payload
// and the lines left before the next 4 KB page, and it only leaves once
// the reorder buffer has reserved a slot for every line in it
module tlp_rd_splitter
(
    input  logic                clk,
    input  logic                reset,

    // avalon read command from the AFU
    input  logic                avm_read,
    input  hc_pkg::line_addr_t  avm_address,
    input  hc_pkg::burst_cnt_t  avm_burstcount,
    output logic                avm_waitrequest,

    // read request packets toward the host
    output logic                tlp_req_valid,
    input  logic                tlp_req_ready,
    output hc_pkg::line_addr_t  tlp_req_addr,
    output hc_pkg::tlp_len_t    tlp_req_len,
    output hc_pkg::rob_idx_t    tlp_req_tag,

    rob_alloc_if.splitter       alloc
);

    // number of line address bits that select a line inside a page
    localparam int PAGE_OFS_W = $clog2(`HC_PAGE_LINES);

    hc_pkg::split_state_t   state;
    hc_pkg::line_addr_t     cur_addr;
    hc_pkg::burst_cnt_t     remaining;

    logic                   cmd_accept;
    logic                   out_free;
    logic                   alloc_take;
    logic                   burst_done;
    logic [PAGE_OFS_W:0]    page_left;
    logic [PAGE_OFS_W:0]    step_w;
    hc_pkg::tlp_len_t       step_len;

    // ==============================
    //  packet sizing
    // ==============================

    // lines from the current address up to the page end, 1 to 512
    assign page_left = (PAGE_OFS_W + 1)'(`HC_PAGE_LINES) - {1'b0, cur_addr[PAGE_OFS_W-1:0]};

    // smallest of max payload, lines left in the burst and lines left in the page
    always_comb
    begin
        step_w = (PAGE_OFS_W + 1)'(`HC_MAX_PAYLOAD_LINES);
        if ((PAGE_OFS_W + 1)'(remaining) < step_w)
        begin
            step_w = (PAGE_OFS_W + 1)'(remaining);
        end
        if (page_left < step_w)
        begin
            step_w = page_left;
        end
    end

    // the result is at most the max payload, so it fits the length field
    assign step_len = hc_pkg::tlp_len_t'(step_w);

    // ==============================
    //  handshakes
    // ==============================

    // waitrequest is low only in idle, so this is the idle acceptance
    assign cmd_accept = avm_read && !avm_waitrequest;

    // the packet register can take a new packet when empty or draining now
    assign out_free = !tlp_req_valid || tlp_req_ready;

    // ask for slots only when a new packet could be loaded this cycle
    assign alloc.alloc_req = (state == hc_pkg::SPLIT_BUSY) && (remaining != '0) && out_free;
    assign alloc.alloc_lines = step_len;
    assign alloc_take = alloc.alloc_req && alloc.alloc_grant;

    // all packets cut and the last one has left or is leaving
    assign burst_done = (remaining == '0) && out_free;

    // ==============================
    //  control FSM
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= hc_pkg::SPLIT_IDLE;
            avm_waitrequest <= 1'b1;
            remaining <= '0;
        end
        else
        begin
            case (state)
                hc_pkg::SPLIT_IDLE:
                begin
                    avm_waitrequest <= 1'b0;
                    if (cmd_accept)
                    begin
                        // hold off further commands until this one is fully issued
                        state <= hc_pkg::SPLIT_BUSY;
                        avm_waitrequest <= 1'b1;
                        remaining <= avm_burstcount;
                    end
                end

                hc_pkg::SPLIT_BUSY:
                begin
                    if (alloc_take)
                    begin
                        remaining <= remaining - hc_pkg::burst_cnt_t'(step_len);
                    end
                    else if (burst_done)
                    begin
                        state <= hc_pkg::SPLIT_IDLE;
                        avm_waitrequest <= 1'b0;
                    end
                end

                default:
                begin
                    state <= hc_pkg::SPLIT_IDLE;
                end
            endcase
        end
    end

    // next packet start address, stepping by the granted length
    always_ff @(posedge clk)
    begin
        if (cmd_accept)
        begin
            cur_addr <= avm_address;
        end
        else if (alloc_take)
        begin
            cur_addr <= cur_addr + hc_pkg::line_addr_t'(step_len);
        end
    end

    // ==============================
    //  packet output register
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tlp_req_valid <= 1'b0;
        end
        else if (alloc_take)
        begin
            tlp_req_valid <= 1'b1;
        end
        else if (tlp_req_ready)
        begin
            tlp_req_valid <= 1'b0;
        end
    end

    // fields change only on a grant, which implies the register is free
    always_ff @(posedge clk)
    begin
        if (alloc_take)
        begin
            tlp_req_addr <= cur_addr;
            tlp_req_len <= step_len;
            // the first reserved slot is the tag, completions offset from it
            tlp_req_tag <= alloc.alloc_idx;
        end
    end

endmodule
